// ==== source/mac_pkg.sv ====
// Shared types and queue sizes of the multiply-accumulate subsystem
package mac_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Queue sizes
  ////////////////////////////////////////////////////////////////////////////

  // Operations waiting between the issue port and the core
  localparam int OP_QUEUE_DEPTH  = 4;
  // Results waiting between the core and the retire port
  localparam int RES_QUEUE_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Operation and result formats
  ////////////////////////////////////////////////////////////////////////////

  // Operation select
  typedef enum logic [2:0] {
    MAC32,   // c + a*b, low word
    MSU32,   // c - a*b, low word
    MUL_I,   // subword product plus c, shifted right
    MUL_IR,  // as MUL_I with rounding
    MUL_H,   // upper word of the 64-bit product, multicycle
    DOT8,    // four byte products plus c
    DOT16    // two halfword products plus c
  } mac_opcode_e;

  // Operation as it crosses the request port, 111 bits
  typedef struct packed {
    mac_opcode_e opcode;
    // Bit 0 marks a as signed, bit 1 marks b as signed
    logic [1:0]  sign_sel;
    // Upper halves for MUL_I and MUL_IR
    logic        subword;
    // Right shift for MUL_I and MUL_IR
    logic [4:0]  imm;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] op_c;
    logic [3:0]  tag;
  } mac_op_t;

  // Result with the tag of its operation, 36 bits
  typedef struct packed {
    logic [3:0]  tag;
    logic [31:0] result;
  } mac_res_t;

  // High-multiply sequencer, one partial product per step
  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

endpackage

// ==== source/op_queue.sv ====
// Synchronous FIFO of one payload type with a single push and pop per cycle
module op_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  // Write side
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  // Read side
  output logic     valid_o,
  output payload_t data_o,
  input  logic     pop_i
);

  // Circular storage
  payload_t mem_q [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  // One bit wider than the pointers, so full and empty differ
  logic [$clog2(DEPTH):0]   count_q;

  assign full_o  = (count_q == DEPTH);
  assign valid_o = (count_q != '0);
  // Head of the queue, visible the cycle after its push
  assign data_o  = mem_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks on the neighbours
  ////////////////////////////////////////////////////////////////////////////

  // Producer honours full
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
  ) else $error("push into a full queue");

  // Consumer honours valid
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) pop_i |-> valid_o
  ) else $error("pop from an empty queue");

endmodule

// ==== source/mac_issue.sv ====
// Four-phase request port that stores one operation per exchange in the queue
module mac_issue (
  input  logic             clk,
  input  logic             rst_n,
  // Request port
  input  logic             op_req_i,
  input  mac_pkg::mac_op_t op_i,
  output logic             op_ack_o,
  // Operation queue write side
  output logic             push_o,
  output mac_pkg::mac_op_t push_data_o,
  input  logic             full_i
);

  // Exchange phase
  // Low while waiting for a request, high from the store until req drops
  logic ack_q;

  // Store once per request, only while the ack is still low
  // A full queue simply postpones the store and with it the ack
  assign push_o      = op_req_i & ~ack_q & ~full_i;

  // Requester keeps op_i stable for as long as req is high
  assign push_data_o = op_i;

  assign op_ack_o    = ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // Phase register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else if (push_o) begin
      // Operation stored, acknowledge on this edge
      ack_q <= 1'b1;
    end else if (!op_req_i) begin
      // Requester released req, close the exchange
      ack_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Ack is held until the requester lets go of req
  a_ack_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (op_ack_o && op_req_i) |=> op_ack_o
  ) else $error("op_ack_o fell while op_req_i was high");

endmodule

// ==== source/mac_core.sv ====
// Multiply-accumulate datapath with a four-step sequencer for the high product
module mac_core (
  input  logic              clk,
  input  logic              rst_n,
  // Operation queue read side
  input  logic              op_valid_i,
  input  mac_pkg::mac_op_t  op_i,
  output logic              op_pop_o,
  // Result queue write side
  output logic              res_push_o,
  output mac_pkg::mac_res_t res_o,
  input  logic              res_full_i
);

  mac_pkg::mulh_state_e state_q;
  mac_pkg::mulh_state_e state_d;

  // Sequencer owns the subword multiplier outside IDLE
  logic        mulh_active;
  // 33rd bit of the running sum, kept from STEP1 to STEP2
  logic        carry_q;
  // Running partial sum of the high product
  logic [31:0] acc_q;

  // Bit 0 takes the upper half of a, bit 1 the upper half of b
  logic [1:0]  sub_sel;
  logic [1:0]  sub_signed;
  logic [4:0]  sub_imm;
  logic        sub_arith;
  logic [16:0] sub_a;
  logic [16:0] sub_b;
  logic [32:0] sub_c;
  logic [33:0] sub_mul;
  logic [31:0] round_tmp;
  logic [31:0] round_val;
  logic [33:0] sub_mac;
  logic        msb_hi;
  logic        msb_lo;
  logic [33:0] sub_shift;

  logic [31:0] prod_lo;
  logic [31:0] int_result;

  logic [3:0][8:0]    dot8_a;
  logic [3:0][8:0]    dot8_b;
  logic [3:0][17:0]   dot8_mul;
  logic [1:0][16:0]   dot16_a;
  logic [1:0][16:0]   dot16_b;
  logic [1:0][31:0]   dot16_mul;
  logic signed [31:0] dot8_sum;
  logic signed [31:0] dot16_sum;

  // Reference products for the high-multiply checks
  logic [63:0] ref_ss;
  logic [63:0] ref_su;
  logic [63:0] ref_uu;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer step controls
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mulh_active = 1'b1;
    sub_sel     = 2'b00;
    sub_signed  = 2'b00;
    sub_imm     = 5'd0;
    sub_arith   = 1'b0;
    case (state_q)
      mac_pkg::IDLE: begin
        // Plain subword multiply straight from the operation
        mulh_active = 1'b0;
        sub_sel     = {2{op_i.subword}};
        sub_signed  = op_i.sign_sel;
        sub_imm     = op_i.imm;
        sub_arith   = op_i.sign_sel[0];
      end
      // AL*BL, unsigned, keep only its upper 16 bits
      mac_pkg::STEP0: sub_imm = 5'd16;
      mac_pkg::STEP1: begin
        // AL*BH, signed with b, result is a 33-bit sum
        sub_sel    = 2'b10;
        sub_signed = {op_i.sign_sel[1], 1'b0};
        sub_arith  = 1'b1;
      end
      mac_pkg::STEP2: begin
        // AH*BL, signed with a, then drop 16 bits
        sub_sel    = 2'b01;
        sub_signed = {1'b0, op_i.sign_sel[0]};
        sub_imm    = 5'd16;
        sub_arith  = 1'b1;
      end
      // AH*BH plus the sum so far gives the upper word
      mac_pkg::FINISH: begin
        sub_sel    = 2'b11;
        sub_signed = op_i.sign_sel;
      end
      default: mulh_active = 1'b0;
    endcase
  end

  // Next state and the pop, which is also the result push
  always_comb begin
    state_d  = state_q;
    op_pop_o = 1'b0;
    case (state_q)
      mac_pkg::IDLE: begin
        if (op_valid_i) begin
          if (op_i.opcode == mac_pkg::MUL_H) begin
            state_d = mac_pkg::STEP0;
          end else begin
            op_pop_o = ~res_full_i;
          end
        end
      end
      mac_pkg::STEP0: state_d = mac_pkg::STEP1;
      mac_pkg::STEP1: state_d = mac_pkg::STEP2;
      mac_pkg::STEP2: state_d = mac_pkg::FINISH;
      mac_pkg::FINISH: begin
        // Wait here while the result queue is full
        if (!res_full_i) begin
          op_pop_o = 1'b1;
          state_d  = mac_pkg::IDLE;
        end
      end
      default: state_d = mac_pkg::IDLE;
    endcase
  end

  assign res_push_o = op_pop_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mac_pkg::IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == mac_pkg::STEP1) begin
        carry_q <= sub_mac[32];
      end else if (state_q == mac_pkg::STEP2) begin
        // Bits 33:32 are shifted back in, nothing to carry on
        carry_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mulh_active && state_q != mac_pkg::FINISH) begin
      acc_q <= sub_shift[31:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // 17x17 subword multiplier with accumulate, round and shift
  ////////////////////////////////////////////////////////////////////////////

  assign sub_a = sub_sel[0] ? {sub_signed[0] & op_i.op_a[31], op_i.op_a[31:16]}
                            : {sub_signed[0] & op_i.op_a[15], op_i.op_a[15:0]};
  assign sub_b = sub_sel[1] ? {sub_signed[1] & op_i.op_b[31], op_i.op_b[31:16]}
                            : {sub_signed[1] & op_i.op_b[15], op_i.op_b[15:0]};

  // STEP0 starts from zero, later steps from the saved sum
  assign sub_c = !mulh_active ? {op_i.op_c[31], op_i.op_c}
               : (state_q == mac_pkg::STEP0) ? '0 : {carry_q, acc_q};

  assign sub_mul   = $signed(sub_a) * $signed(sub_b);
  // Half of 2^imm, zero for imm of zero
  assign round_tmp = 32'h1 << op_i.imm;
  assign round_val = (op_i.opcode == mac_pkg::MUL_IR) ? {1'b0, round_tmp[31:1]} : '0;
  assign sub_mac   = $signed(sub_c) + $signed(sub_mul) + $signed(round_val);

  // Sequencer keeps 34 bits, plain ops sign-extend from bit 31
  assign msb_hi    = mulh_active ? sub_mac[33] : sub_mac[31];
  assign msb_lo    = mulh_active ? sub_mac[32] : sub_mac[31];
  assign sub_shift = $signed({sub_arith & msb_hi, sub_arith & msb_lo, sub_mac[31:0]}) >>> sub_imm;

  ////////////////////////////////////////////////////////////////////////////
  // 32-bit multiply-accumulate and dot products
  ////////////////////////////////////////////////////////////////////////////

  // Low word needs no signedness
  assign prod_lo    = op_i.op_a * op_i.op_b;
  assign int_result = (op_i.opcode == mac_pkg::MSU32) ? op_i.op_c - prod_lo
                                                      : op_i.op_c + prod_lo;

  always_comb begin
    dot8_sum  = $signed(op_i.op_c);
    dot16_sum = $signed(op_i.op_c);
    for (int i = 0; i < 4; i++) begin
      dot8_a[i]   = {op_i.sign_sel[0] & op_i.op_a[8*i+7], op_i.op_a[8*i +: 8]};
      dot8_b[i]   = {op_i.sign_sel[1] & op_i.op_b[8*i+7], op_i.op_b[8*i +: 8]};
      dot8_mul[i] = $signed(dot8_a[i]) * $signed(dot8_b[i]);
      dot8_sum    = dot8_sum + $signed(dot8_mul[i]);
    end
    for (int i = 0; i < 2; i++) begin
      dot16_a[i]   = {op_i.sign_sel[0] & op_i.op_a[16*i+15], op_i.op_a[16*i +: 16]};
      dot16_b[i]   = {op_i.sign_sel[1] & op_i.op_b[16*i+15], op_i.op_b[16*i +: 16]};
      // Low word of the product is all the sum needs
      dot16_mul[i] = $signed(dot16_a[i]) * $signed(dot16_b[i]);
      dot16_sum    = dot16_sum + $signed(dot16_mul[i]);
    end
  end

  // Result select, tag rides along
  always_comb begin
    res_o.tag = op_i.tag;
    case (op_i.opcode)
      mac_pkg::MAC32, mac_pkg::MSU32:               res_o.result = int_result;
      mac_pkg::MUL_I, mac_pkg::MUL_IR, mac_pkg::MUL_H: res_o.result = sub_shift[31:0];
      mac_pkg::DOT8:                                res_o.result = dot8_sum;
      mac_pkg::DOT16:                               res_o.result = dot16_sum;
      default:                                      res_o.result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  assign ref_ss = {{32{op_i.op_a[31]}}, op_i.op_a} * {{32{op_i.op_b[31]}}, op_i.op_b};
  assign ref_su = {{32{op_i.op_a[31]}}, op_i.op_a} * {32'b0, op_i.op_b};
  assign ref_uu = {32'b0, op_i.op_a} * {32'b0, op_i.op_b};

  a_mulh_ss: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mac_pkg::FINISH && op_i.sign_sel == 2'b11) |-> res_o.result == ref_ss[63:32]
  ) else $error("signed high product mismatch");

  a_mulh_su: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mac_pkg::FINISH && op_i.sign_sel == 2'b01) |-> res_o.result == ref_su[63:32]
  ) else $error("signed-unsigned high product mismatch");

  a_mulh_uu: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mac_pkg::FINISH && op_i.sign_sel == 2'b00) |-> res_o.result == ref_uu[63:32]
  ) else $error("unsigned high product mismatch");

  // Back-pressure from the result queue holds the finished product
  a_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mac_pkg::FINISH && res_full_i) |=> state_q == mac_pkg::FINISH
  ) else $error("sequencer left FINISH with the result queue full");

endmodule

// ==== source/mac_retire.sv ====
// Four-phase response port that hands out one queued result per exchange
module mac_retire (
  input  logic              clk,
  input  logic              rst_n,
  // Result queue read side
  input  logic              valid_i,
  input  mac_pkg::mac_res_t data_i,
  output logic              pop_o,
  // Response port
  output logic              res_req_o,
  output mac_pkg::mac_res_t res_o,
  input  logic              res_ack_i
);

  // Request state, low when idle and high while a result is offered
  logic              req_q;
  // Offered result, held for the whole exchange
  mac_pkg::mac_res_t res_q;
  // Start of an exchange
  logic              raise;

  // Idle, something queued, and the last ack already gone
  assign raise     = ~req_q & valid_i & ~res_ack_i;
  // Ack seen, the head is delivered
  assign pop_o     = req_q & res_ack_i;

  assign res_req_o = req_q;
  assign res_o     = res_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (raise) begin
      req_q <= 1'b1;
    end else if (pop_o) begin
      // Drop req on the popping edge
      req_q <= 1'b0;
    end
  end

  // Capture the head when the request goes out
  always_ff @(posedge clk) begin
    if (raise) begin
      res_q <= data_i;
    end
  end

  // Offered result does not move under the requester
  a_res_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    res_req_o |=> (!res_req_o || $stable(res_o))
  ) else $error("res_o changed while res_req_o was high");

endmodule

// ==== source/mac_top.sv ====
// Multiply-accumulate subsystem with four-phase ports and request/result queues
module mac_top (
  input  logic              clk,
  input  logic              rst_n,
  // Request port
  input  logic              op_req_i,
  input  mac_pkg::mac_op_t  op_i,
  output logic              op_ack_o,
  // Response port
  output logic              res_req_o,
  output mac_pkg::mac_res_t res_o,
  input  logic              res_ack_i
);

  // Issue to operation queue
  logic              op_push;
  mac_pkg::mac_op_t  op_push_data;
  logic              op_full;
  // Operation queue to core
  logic              op_valid;
  mac_pkg::mac_op_t  op_head;
  logic              op_pop;
  // Core to result queue
  logic              res_push;
  mac_pkg::mac_res_t res_push_data;
  logic              res_full;
  // Result queue to retire
  logic              res_valid;
  mac_pkg::mac_res_t res_head;
  logic              res_pop;

  mac_issue u_mac_issue (
    .clk, .rst_n, .op_req_i, .op_i, .op_ack_o,
    .push_o(op_push), .push_data_o(op_push_data), .full_i(op_full)
  );

  op_queue #(.payload_t(mac_pkg::mac_op_t), .DEPTH(mac_pkg::OP_QUEUE_DEPTH)) u_op_queue (
    .clk, .rst_n, .push_i(op_push), .data_i(op_push_data), .full_o(op_full),
    .valid_o(op_valid), .data_o(op_head), .pop_i(op_pop)
  );

  mac_core u_mac_core (
    .clk, .rst_n, .op_valid_i(op_valid), .op_i(op_head), .op_pop_o(op_pop),
    .res_push_o(res_push), .res_o(res_push_data), .res_full_i(res_full)
  );

  op_queue #(.payload_t(mac_pkg::mac_res_t), .DEPTH(mac_pkg::RES_QUEUE_DEPTH)) u_res_queue (
    .clk, .rst_n, .push_i(res_push), .data_i(res_push_data), .full_o(res_full),
    .valid_o(res_valid), .data_o(res_head), .pop_i(res_pop)
  );

  mac_retire u_mac_retire (
    .clk, .rst_n, .valid_i(res_valid), .data_i(res_head), .pop_o(res_pop),
    .res_req_o, .res_o, .res_ack_i
  );

endmodule

// ==== sim/tb_mac_model.svh ====
// Reference model that gives the expected result word of every MAC opcode
`ifndef TB_MAC_MODEL_SVH
`define TB_MAC_MODEL_SVH

// Operand widening, sign or zero extension to 64 bits
function automatic logic signed [63:0] widen_byte(input logic [7:0] v, input logic sgn);
  return sgn ? {{56{v[7]}}, v} : {56'b0, v};
endfunction

function automatic logic signed [63:0] widen_half(input logic [15:0] v, input logic sgn);
  return sgn ? {{48{v[15]}}, v} : {48'b0, v};
endfunction

function automatic logic signed [63:0] widen_word(input logic [31:0] v, input logic sgn);
  return sgn ? {{32{v[31]}}, v} : {32'b0, v};
endfunction

function automatic logic [31:0] expected_result(input mac_pkg::mac_op_t op);
  logic signed [63:0] prod;
  logic signed [63:0] sum;
  logic [31:0]        word;
  logic signed [31:0] sword;
  logic [31:0]        rnd;
  expected_result = '0;
  case (op.opcode)
    mac_pkg::MAC32: expected_result = op.op_c + op.op_a * op.op_b;
    mac_pkg::MSU32: expected_result = op.op_c - op.op_a * op.op_b;
    mac_pkg::MUL_I, mac_pkg::MUL_IR: begin
      prod = widen_half(op.subword ? op.op_a[31:16] : op.op_a[15:0], op.sign_sel[0])
           * widen_half(op.subword ? op.op_b[31:16] : op.op_b[15:0], op.sign_sel[1]);
      // Half of 2^imm, none for a zero shift
      rnd  = (op.opcode == mac_pkg::MUL_IR && op.imm != 0) ? 32'h1 << (op.imm - 1) : 32'h0;
      word = op.op_c + prod[31:0] + rnd;
      sword = word;
      if (op.sign_sel[0]) expected_result = sword >>> op.imm;
      else expected_result = word >> op.imm;
    end
    mac_pkg::MUL_H: begin
      prod = widen_word(op.op_a, op.sign_sel[0]) * widen_word(op.op_b, op.sign_sel[1]);
      expected_result = prod[63:32];
    end
    mac_pkg::DOT8: begin
      sum = widen_word(op.op_c, 1'b1);
      for (int i = 0; i < 4; i++) begin
        sum = sum + widen_byte(op.op_a[8*i +: 8], op.sign_sel[0])
                  * widen_byte(op.op_b[8*i +: 8], op.sign_sel[1]);
      end
      expected_result = sum[31:0];
    end
    mac_pkg::DOT16: begin
      sum = widen_word(op.op_c, 1'b1);
      for (int i = 0; i < 2; i++) begin
        sum = sum + widen_half(op.op_a[16*i +: 16], op.sign_sel[0])
                  * widen_half(op.op_b[16*i +: 16], op.sign_sel[1]);
      end
      expected_result = sum[31:0];
    end
    default: expected_result = '0;
  endcase
endfunction

`endif

// ==== sim/tb_mac_top.sv ====
// Testbench of the MAC subsystem, random and corner operations through both ports
module tb_mac_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REQ_TIMEOUT   = 500;
  localparam int DRAIN_TIMEOUT = 2000;

  logic              clk;
  logic              rst_n;
  logic              op_req;
  mac_pkg::mac_op_t  op;
  logic              op_ack;
  logic              res_req;
  mac_pkg::mac_res_t res;
  logic              res_ack;

  // Operations sent and not yet returned, oldest first
  mac_pkg::mac_op_t sent_q[$];
  logic [3:0] next_tag;
  logic       started;
  logic       hold_resp;
  logic       ack_prev;
  int         n_sent;
  int         n_checked;
  int         ack_rises;
  int         wait_cnt;
  int         wait_target;

  `include "tb_mac_model.svh"

  mac_top u_dut (
    .clk, .rst_n, .op_req_i(op_req), .op_i(op), .op_ack_o(op_ack),
    .res_req_o(res_req), .res_o(res), .res_ack_i(res_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // Quiet ports until the first request
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> (!op_ack && !res_req)
  ) else report_failure($sformatf("[ERROR] %0t: port active before any request", $time));

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(op_ack) |-> $past(op_req)
  ) else report_failure($sformatf("[ERROR] %0t: op_ack_o rose without a request", $time));

  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(op_ack) |-> !$past(op_req)
  ) else report_failure($sformatf("[ERROR] %0t: op_ack_o fell before op_req_i", $time));

  a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (res_req && $past(res_req)) |-> $stable(res)
  ) else report_failure($sformatf("[ERROR] %0t: res_o moved while res_req_o high", $time));

  // One ack pulse per exchange
  always @(posedge clk) begin
    if (!rst_n) begin
      ack_prev  <= 1'b0;
      ack_rises <= 0;
    end else begin
      ack_prev <= op_ack;
      if (op_ack && !ack_prev) ack_rises <= ack_rises + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response side, random ack delay and scoreboard compare
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : respond
    mac_pkg::mac_op_t exp_op;
    logic [31:0]      exp_val;
    if (!rst_n) begin
      res_ack     <= 1'b0;
      wait_cnt    <= 0;
      wait_target <= 0;
    end else if (res_ack) begin
      // Close the exchange once req is gone
      if (!res_req) begin
        res_ack     <= 1'b0;
        wait_cnt    <= 0;
        wait_target <= $urandom_range(12, 0);
      end
    end else if (res_req && !hold_resp) begin
      if (wait_cnt < wait_target) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        assert (sent_q.size() > 0)
          else report_failure($sformatf("[ERROR] %0t: result with no operation pending", $time));
        exp_op  = sent_q.pop_front();
        exp_val = expected_result(exp_op);
        assert (res.tag == exp_op.tag && res.result == exp_val)
          else report_failure($sformatf(
            "[ERROR] %0t: opcode %s got tag %0d result %h, expected tag %0d result %h",
            $time, exp_op.opcode.name(), res.tag, res.result, exp_op.tag, exp_val));
        n_checked++;
        res_ack <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic mac_pkg::mac_op_t random_op(input mac_pkg::mac_opcode_e opc);
    mac_pkg::mac_op_t o;
    o.opcode   = opc;
    o.sign_sel = 2'($urandom);
    o.subword  = 1'($urandom);
    o.imm      = 5'($urandom);
    o.op_a     = $urandom;
    o.op_b     = $urandom;
    o.op_c     = $urandom;
    o.tag      = '0;
    // High multiply covers signed, signed-unsigned and unsigned only
    if (opc == mac_pkg::MUL_H && o.sign_sel == 2'b10) o.sign_sel = 2'b11;
    return o;
  endfunction

  // One full four-phase exchange on the request port
  task automatic send_op(input mac_pkg::mac_op_t o_in);
    mac_pkg::mac_op_t o;
    int               cycles;
    o        = o_in;
    o.tag    = next_tag;
    next_tag = next_tag + 1'b1;
    sent_q.push_back(o);
    n_sent++;
    started  = 1'b1;
    @(posedge clk);
    op     <= o;
    op_req <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > REQ_TIMEOUT) report_failure("timeout waiting for op_ack_o to rise");
    end while (!op_ack);
    op_req <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > REQ_TIMEOUT) report_failure("timeout waiting for op_ack_o to fall");
    end while (op_ack);
  endtask

  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while (sent_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        report_failure($sformatf("timeout waiting for the %s results to return", what));
      end
    end
  endtask

  initial begin : main
    mac_pkg::mac_op_t o;
    logic [31:0]      corner [5];
    logic [1:0]       mulh_sel [3];
    void'($urandom(32'h09bc46ab));
    rst_n     = 1'b0;
    op_req    = 1'b0;
    op        = '0;
    res_ack   = 1'b0;
    hold_resp = 1'b0;
    started   = 1'b0;
    next_tag  = '0;
    n_sent    = 0;
    n_checked = 0;
    corner    = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001, 32'h0};
    mulh_sel  = '{2'b11, 2'b01, 2'b00};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Idle ports are watched by a_quiet meanwhile
    repeat (8) @(posedge clk);

    for (int n = 0; n < 200; n++) begin
      send_op(random_op(($urandom % 2) ? mac_pkg::MSU32 : mac_pkg::MAC32));
    end
    wait_drain("MAC32 and MSU32");

    // Every sign_sel and subword pairing, random shift
    for (int n = 0; n < 64; n++) begin
      o = random_op(($urandom % 2) ? mac_pkg::MUL_IR : mac_pkg::MUL_I);
      o.sign_sel = 2'(n);
      o.subword  = 1'(n >> 2);
      send_op(o);
    end
    wait_drain("MUL_I and MUL_IR");

    // Corner operand pairs then random ones, per signedness
    for (int s = 0; s < 3; s++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          o = random_op(mac_pkg::MUL_H);
          o.sign_sel = mulh_sel[s];
          o.op_a     = corner[i];
          o.op_b     = corner[j];
          send_op(o);
        end
      end
      for (int n = 0; n < 8; n++) begin
        o = random_op(mac_pkg::MUL_H);
        o.sign_sel = mulh_sel[s];
        send_op(o);
      end
    end
    wait_drain("MUL_H");

    for (int n = 0; n < 64; n++) begin
      o = random_op((n % 2) ? mac_pkg::DOT16 : mac_pkg::DOT8);
      o.sign_sel = 2'(n >> 1);
      send_op(o);
    end
    wait_drain("DOT8 and DOT16");

    // Burst of mixed operations while results sit unacknowledged
    // The result queue fills and the core stalls behind it
    hold_resp <= 1'b1;
    fork
      for (int n = 0; n < 12; n++) begin
        send_op(random_op(mac_pkg::mac_opcode_e'(3'($urandom_range(6, 0)))));
      end
      begin
        repeat (30) @(posedge clk);
        hold_resp <= 1'b0;
      end
    join
    wait_drain("back-pressure burst");
    repeat (4) @(posedge clk);

    if (n_checked == n_sent && ack_rises == n_sent) begin
      $display("all tests passed");
    end else begin
      report_failure($sformatf("[ERROR] %0t: %0d sent, %0d acked, %0d returned",
                               $time, n_sent, ack_rises, n_checked));
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+sim
source/mac_pkg.sv
source/op_queue.sv
source/mac_issue.sv
source/mac_core.sv
source/mac_retire.sv
source/mac_top.sv
sim/tb_mac_top.sv
